/* common/ipv4_fwd_pkg.sv */
// IPv4 forwarding stage shared definitions

package ipv4_fwd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Beat geometry

    localparam int BEAT_BYTES = 8;
    localparam int BEAT_BITS  = BEAT_BYTES * 8;

    typedef logic [BEAT_BITS-1:0]  beat_data_t;
    typedef logic [BEAT_BYTES-1:0] beat_keep_t;
    typedef logic [2:0]            beat_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Header offsets, byte 0 of a beat in bits 7:0

    localparam logic [15:0] IPV4_ETHER_TYPE = 16'h0800;

    localparam beat_idx_t ETHER_TYPE_BEAT = 3'd1;
    localparam int        ETHER_TYPE_LANE = 4;
    localparam beat_idx_t TTL_BEAT        = 3'd2;
    localparam int        TTL_LANE        = 6;
    localparam beat_idx_t CHECKSUM_BEAT   = 3'd3;
    localparam int        CHECKSUM_LANE   = 0;
    localparam beat_idx_t HDR_FIRST_BEAT  = 3'd1;
    localparam int        HDR_FIRST_LANE  = 6;
    localparam beat_idx_t HDR_LAST_BEAT   = 3'd4;
    localparam int        HDR_LAST_LANE   = 1;

    localparam int PIPE_LATENCY = 2;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        HEADER  = 2'd1,
        PAYLOAD = 2'd2
    } parse_state_t;

    // Ones'-complement add with end-around carry
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

/* source/beat_counter.sv */
// Beat index within a packet

`timescale 1ns/1ps

module beat_counter (
    input  logic                    core_clk_ifc,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_last,
    output ipv4_fwd_pkg::beat_idx_t beat_idx
);
    import ipv4_fwd_pkg::*;

    // All payload beats share this index
    localparam beat_idx_t PAYLOAD_IDX = HDR_LAST_BEAT + 3'd1;

    beat_idx_t idx_q;

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (in_valid) begin
            if (in_last) begin
                idx_q <= '0;
            end else if (idx_q != PAYLOAD_IDX) begin
                idx_q <= idx_q + 3'd1;
            end
        end
    end

    // Index of the beat currently on the input
    assign beat_idx = idx_q;

endmodule

/* source/pkt_parse_fsm.sv */
// Packet parser and status generation

`timescale 1ns/1ps

module pkt_parse_fsm (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  ipv4_fwd_pkg::beat_data_t in_data,
    input  ipv4_fwd_pkg::beat_idx_t  beat_idx,
    input  logic                     checksum_ok,
    output logic                     rewrite_en,
    output logic [7:0]               ttl,
    output logic                     status_valid,
    output logic                     status_is_ipv4,
    output logic                     status_ttl_expired,
    output logic                     status_checksum_ok
);
    import ipv4_fwd_pkg::*;

    parse_state_t            state;
    parse_state_t            state_next;
    logic                    is_ipv4;
    logic                    last_evt;
    logic [PIPE_LATENCY-1:0] last_pipe;
    logic [15:0]             ether_type;

    // EtherType is big endian on the wire
    assign ether_type = {in_data[ETHER_TYPE_LANE*8 +: 8], in_data[(ETHER_TYPE_LANE+1)*8 +: 8]};
    assign last_evt   = in_valid && in_last;

    //////////////////////////////////////////////////////////////////////
    // State machine

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (in_valid && !in_last) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                if (last_evt) begin
                    state_next = IDLE;
                end else if (in_valid && beat_idx == HDR_LAST_BEAT) begin
                    state_next = PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (last_evt) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            is_ipv4   <= 1'b0;
            ttl       <= 8'd0;
            last_pipe <= '0;
        end else begin
            state     <= state_next;
            last_pipe <= {last_pipe[PIPE_LATENCY-2:0], last_evt};
            if (in_valid && state == HEADER) begin
                if (beat_idx == ETHER_TYPE_BEAT) begin
                    is_ipv4 <= (ether_type == IPV4_ETHER_TYPE);
                end
                if (beat_idx == TTL_BEAT) begin
                    ttl <= in_data[TTL_LANE*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Rewrite control and status

    assign rewrite_en = is_ipv4 && (ttl != 8'd0);

    // Lines up with the output beat carrying last
    assign status_valid       = last_pipe[PIPE_LATENCY-1];
    assign status_is_ipv4     = is_ipv4;
    assign status_ttl_expired = is_ipv4 && (ttl == 8'd0);
    assign status_checksum_ok = is_ipv4 && checksum_ok;

endmodule

/* source/hdr_checksum_verify.sv */
// IPv4 header checksum check

`timescale 1ns/1ps

module hdr_checksum_verify (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  ipv4_fwd_pkg::beat_data_t in_data,
    input  ipv4_fwd_pkg::beat_idx_t  beat_idx,
    output logic                     checksum_ok
);
    import ipv4_fwd_pkg::*;

    logic [15:0] acc;
    logic [15:0] beat_sum;
    logic [15:0] total;

    // Sum of the header words carried by this beat
    always_comb begin : beat_words
        logic [15:0] word;
        logic        take;
        beat_sum = 16'd0;
        for (int w = 0; w < BEAT_BYTES / 2; w++) begin
            word = {in_data[w*16 +: 8], in_data[w*16+8 +: 8]};
            take = ((beat_idx == HDR_FIRST_BEAT) && (w*2 >= HDR_FIRST_LANE)) ||
                   ((beat_idx > HDR_FIRST_BEAT) && (beat_idx < HDR_LAST_BEAT)) ||
                   ((beat_idx == HDR_LAST_BEAT) && (w*2 + 1 <= HDR_LAST_LANE));
            if (take) begin
                beat_sum = ones_add(beat_sum, word);
            end
        end
    end

    assign total = ones_add(acc, beat_sum);

    // Running sum, restarted on the first header beat
    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            if (beat_idx == HDR_FIRST_BEAT) begin
                acc <= beat_sum;
            end else if (beat_idx <= HDR_LAST_BEAT) begin
                acc <= total;
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            checksum_ok <= 1'b0;
        end else if (in_valid && beat_idx == HDR_LAST_BEAT) begin
            checksum_ok <= (total == 16'hFFFF);
        end
    end

endmodule

/* source/ttl_rewrite.sv */
// TTL and checksum rewrite pipeline

`timescale 1ns/1ps

module ttl_rewrite (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     in_last,
    input  ipv4_fwd_pkg::beat_data_t in_data,
    input  ipv4_fwd_pkg::beat_keep_t in_keep,
    input  ipv4_fwd_pkg::beat_idx_t  beat_idx,
    input  logic                     rewrite_en,
    input  logic [7:0]               ttl,
    output logic                     out_valid,
    output logic                     out_last,
    output ipv4_fwd_pkg::beat_data_t out_data,
    output ipv4_fwd_pkg::beat_keep_t out_keep
);
    import ipv4_fwd_pkg::*;

    logic        s1_valid;
    logic        s1_last;
    beat_data_t  s1_data;
    beat_keep_t  s1_keep;
    beat_idx_t   s1_idx;
    logic [7:0]  proto_q;
    logic [15:0] old_csum;
    logic [15:0] new_csum;
    beat_data_t  s2_data_next;

    //////////////////////////////////////////////////////////////////////
    // Stage 1

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s1_last  <= in_valid && in_last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            s1_data <= in_data;
            s1_keep <= in_keep;
            s1_idx  <= beat_idx;
        end
        // Protocol byte follows the TTL in beat 2
        if (s1_valid && s1_idx == TTL_BEAT) begin
            proto_q <= s1_data[(TTL_LANE+1)*8 +: 8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, RFC 1624 eqn 3 on the {TTL, protocol} word

    assign old_csum = {s1_data[CHECKSUM_LANE*8 +: 8], s1_data[(CHECKSUM_LANE+1)*8 +: 8]};
    assign new_csum = ~ones_add(ones_add(~old_csum, ~{ttl, proto_q}), {ttl - 8'd1, proto_q});

    always_comb begin
        s2_data_next = s1_data;
        if (rewrite_en && s1_idx == TTL_BEAT) begin
            s2_data_next[TTL_LANE*8 +: 8] = ttl - 8'd1;
        end
        if (rewrite_en && s1_idx == CHECKSUM_BEAT) begin
            s2_data_next[CHECKSUM_LANE*8 +: 8]     = new_csum[15:8];
            s2_data_next[(CHECKSUM_LANE+1)*8 +: 8] = new_csum[7:0];
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            out_last  <= s1_valid && s1_last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (s1_valid) begin
            out_data <= s2_data_next;
            out_keep <= s1_keep;
        end
    end

endmodule

/* source/ipv4_fwd_top.sv */
// IPv4 forwarding stage top level

`timescale 1ns/1ps

module ipv4_fwd_top (
    input  logic                     core_clk_ifc,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  ipv4_fwd_pkg::beat_data_t in_data,
    input  ipv4_fwd_pkg::beat_keep_t in_keep,
    input  logic                     in_last,
    output logic                     out_valid,
    output ipv4_fwd_pkg::beat_data_t out_data,
    output ipv4_fwd_pkg::beat_keep_t out_keep,
    output logic                     out_last,
    output logic                     status_valid,
    output logic                     status_is_ipv4,
    output logic                     status_ttl_expired,
    output logic                     status_checksum_ok
);
    import ipv4_fwd_pkg::*;

    beat_idx_t   beat_idx;
    logic        checksum_ok;
    logic        rewrite_en;
    logic [7:0]  ttl;

    beat_counter u_beat_counter (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .beat_idx     (beat_idx)
    );

    pkt_parse_fsm u_pkt_parse_fsm (
        .core_clk_ifc       (core_clk_ifc),
        .rst_n              (rst_n),
        .in_valid           (in_valid),
        .in_last            (in_last),
        .in_data            (in_data),
        .beat_idx           (beat_idx),
        .checksum_ok        (checksum_ok),
        .rewrite_en         (rewrite_en),
        .ttl                (ttl),
        .status_valid       (status_valid),
        .status_is_ipv4     (status_is_ipv4),
        .status_ttl_expired (status_ttl_expired),
        .status_checksum_ok (status_checksum_ok)
    );

    hdr_checksum_verify u_hdr_checksum_verify (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .beat_idx     (beat_idx),
        .checksum_ok  (checksum_ok)
    );

    ttl_rewrite u_ttl_rewrite (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .beat_idx     (beat_idx),
        .rewrite_en   (rewrite_en),
        .ttl          (ttl),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_keep     (out_keep)
    );

endmodule

/* verif/ipv4_fwd_ref.svh */
// IPv4 forwarding reference model

`ifndef IPV4_FWD_REF_SVH
`define IPV4_FWD_REF_SVH

// Room for the longest frame, byte k in bits 8k+7:8k
localparam int FRAME_BITS = 2048;

function automatic logic [7:0] get_byte(input logic [FRAME_BITS-1:0] frame, input int idx);
    return frame[idx*8 +: 8];
endfunction

// End-around carry fold of a wide sum
function automatic logic [15:0] fold_sum(input logic [31:0] total);
    logic [31:0] t;
    t = total;
    while (t[31:16] != 16'd0) begin
        t = {16'd0, t[15:0]} + {16'd0, t[31:16]};
    end
    return t[15:0];
endfunction

// Ones'-complement sum of the ten header words, word 5 is the checksum
function automatic logic [15:0] header_sum(input logic [FRAME_BITS-1:0] frame,
                                           input logic skip_csum);
    logic [31:0] total;
    total = 32'd0;
    for (int i = 0; i < 10; i++) begin
        if (!(skip_csum && i == 5)) begin
            total = total + {16'd0, get_byte(frame, 14 + 2*i), get_byte(frame, 15 + 2*i)};
        end
    end
    return fold_sum(total);
endfunction

// Random frame with an Ethernet II and IPv4 header, optional checksum bit flip
task automatic build_frame(input int len, input logic [15:0] ether_type, input logic [7:0] ttl,
                           input int flip_bit, output logic [FRAME_BITS-1:0] frame);
    logic [31:0] rnd;
    logic [15:0] tot_len;
    logic [15:0] csum;
    frame   = '0;
    tot_len = 16'(len - 14);
    for (int i = 0; i < len; i++) begin
        rnd = $random(seed);
        frame[i*8 +: 8] = rnd[7:0];
    end
    frame[12*8 +: 8] = ether_type[15:8];
    frame[13*8 +: 8] = ether_type[7:0];
    // Version 4 with five header words, DF set
    frame[14*8 +: 8] = 8'h45;
    frame[16*8 +: 8] = tot_len[15:8];
    frame[17*8 +: 8] = tot_len[7:0];
    frame[20*8 +: 8] = 8'h40;
    frame[21*8 +: 8] = 8'h00;
    frame[22*8 +: 8] = ttl;
    csum = ~header_sum(frame, 1'b1);
    if (flip_bit >= 0) begin
        csum = csum ^ (16'd1 << flip_bit);
    end
    frame[24*8 +: 8] = csum[15:8];
    frame[25*8 +: 8] = csum[7:0];
endtask

// Expected output frame, returns {is_ipv4, ttl_expired, checksum_ok}
function automatic logic [2:0] expected_frame(input logic [FRAME_BITS-1:0] frame,
                                              output logic [FRAME_BITS-1:0] result);
    logic        is_ipv4;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] old_csum;
    logic [15:0] new_csum;
    logic [31:0] total;
    result   = frame;
    is_ipv4  = {get_byte(frame, 12), get_byte(frame, 13)} == 16'h0800;
    ttl      = get_byte(frame, 22);
    proto    = get_byte(frame, 23);
    old_csum = {get_byte(frame, 24), get_byte(frame, 25)};
    if (is_ipv4 && ttl != 8'd0) begin
        // RFC 1624 eqn 3, HC' = ~(~HC + ~m + m')
        total    = {16'd0, ~old_csum} + {16'd0, ~{ttl, proto}} + {16'd0, ttl - 8'd1, proto};
        new_csum = ~fold_sum(total);
        result[22*8 +: 8] = ttl - 8'd1;
        result[24*8 +: 8] = new_csum[15:8];
        result[25*8 +: 8] = new_csum[7:0];
    end
    return {is_ipv4, is_ipv4 && ttl == 8'd0, is_ipv4 && header_sum(frame, 1'b0) == 16'hFFFF};
endfunction

`endif

/* verif/ipv4_fwd_tb.sv */
// IPv4 forwarding stage testbench

`timescale 1ns/1ps

module ipv4_fwd_tb;
    import ipv4_fwd_pkg::*;

    logic       core_clk_ifc;
    logic       rst_n;
    logic       in_valid;
    beat_data_t in_data;
    beat_keep_t in_keep;
    logic       in_last;
    logic       out_valid;
    beat_data_t out_data;
    beat_keep_t out_keep;
    logic       out_last;
    logic       status_valid;
    logic       status_is_ipv4;
    logic       status_ttl_expired;
    logic       status_checksum_ok;

    integer     seed;
    int         errors = 0;
    int         pkt_count;
    int         status_count = 0;
    logic       timed_out;

    beat_data_t exp_data_q[$];
    beat_keep_t exp_keep_q[$];
    logic       exp_last_q[$];
    logic [2:0] exp_status_q[$];

    `include "ipv4_fwd_ref.svh"

    // Input history for the latency check, index 1 is two cycles back
    logic [1:0]            valid_hist = '0;
    logic [1:0]            last_hist = '0;
    logic [FRAME_BITS-1:0] out_frame;
    int                    out_beat = 0;
    logic [2:0]            exp_status;

    ipv4_fwd_top u_ipv4_fwd_top (
        .core_clk_ifc       (core_clk_ifc),
        .rst_n              (rst_n),
        .in_valid           (in_valid),
        .in_data            (in_data),
        .in_keep            (in_keep),
        .in_last            (in_last),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .out_keep           (out_keep),
        .out_last           (out_last),
        .status_valid       (status_valid),
        .status_is_ipv4     (status_is_ipv4),
        .status_ttl_expired (status_ttl_expired),
        .status_checksum_ok (status_checksum_ok)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error: %s = %0h, expected %0h at %0t", name, actual, expected, $time);
        end
    endtask

    // Builds one frame, queues its expected beats and drives it
    task automatic send_packet(input int len, input logic [15:0] ether_type,
                               input logic [7:0] ttl, input int flip_bit, input int max_gap);
        logic [FRAME_BITS-1:0] frame;
        logic [FRAME_BITS-1:0] expected;
        logic [31:0]           rnd;
        logic [2:0]            status;
        beat_keep_t            keep;
        int                    beats;
        int                    gap;
        build_frame(len, ether_type, ttl, flip_bit, frame);
        status = expected_frame(frame, expected);
        exp_status_q.push_back(status);
        beats = (len + BEAT_BYTES - 1) / BEAT_BYTES;
        pkt_count++;
        for (int b = 0; b < beats; b++) begin
            keep = (b == beats - 1) ? beat_keep_t'((1 << (len - b * BEAT_BYTES)) - 1) : '1;
            exp_data_q.push_back(expected[b*BEAT_BITS +: BEAT_BITS]);
            exp_keep_q.push_back(keep);
            exp_last_q.push_back(b == beats - 1);
            @(posedge core_clk_ifc);
            in_valid <= 1'b1;
            in_data  <= frame[b*BEAT_BITS +: BEAT_BITS];
            in_keep  <= keep;
            in_last  <= (b == beats - 1);
            rnd = $random(seed);
            gap = int'(rnd[7:0]) % (max_gap + 1);
            repeat (gap) begin
                @(posedge core_clk_ifc);
                in_valid <= 1'b0;
                in_last  <= 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process, samples on the falling edge

    always @(negedge core_clk_ifc) begin
        if (rst_n) begin
            check_value("out_valid", 64'(out_valid), 64'(valid_hist[1]));
            check_value("status_valid", 64'(status_valid), 64'(last_hist[1]));
            if (out_valid) begin
                if (exp_data_q.size() == 0) begin
                    errors = errors + 1;
                    $display("Output beat at %0t with no expected beat pending", $time);
                end else begin
                    check_value("out_data", out_data, exp_data_q.pop_front());
                    check_value("out_keep", 64'(out_keep), 64'(exp_keep_q.pop_front()));
                    check_value("out_last", 64'(out_last), 64'(exp_last_q.pop_front()));
                end
                out_frame[out_beat*BEAT_BITS +: BEAT_BITS] = out_data;
                out_beat = out_last ? 0 : out_beat + 1;
            end
            if (status_valid) begin
                status_count++;
                if (exp_status_q.size() == 0) begin
                    errors = errors + 1;
                    $display("Status pulse at %0t with no packet pending", $time);
                end else begin
                    exp_status = exp_status_q.pop_front();
                    check_value("status_is_ipv4", 64'(status_is_ipv4), 64'(exp_status[2]));
                    check_value("status_ttl_expired", 64'(status_ttl_expired),
                                64'(exp_status[1]));
                    check_value("status_checksum_ok", 64'(status_checksum_ok),
                                64'(exp_status[0]));
                    // Sound header must still sum to FFFF after the rewrite
                    if (exp_status[0]) begin
                        check_value("out header sum", 64'(header_sum(out_frame, 1'b0)),
                                    64'hFFFF);
                    end
                end
            end
        end
        valid_hist = {valid_hist[0], in_valid};
        last_hist  = {last_hist[0], in_valid && in_last};
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [31:0] rnd;
        int          kind;
        int          wait_cycles;
        seed      = 7;
        pkt_count = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_keep   = '0;
        in_last   = 1'b0;
        repeat (16) @(posedge core_clk_ifc);
        rst_n <= 1'b1;

        // Directed frames, TTL corners, foreign EtherType, bad checksum
        send_packet(64, IPV4_ETHER_TYPE, 8'd64, -1, 0);
        send_packet(98, IPV4_ETHER_TYPE, 8'd255, -1, 0);
        send_packet(71, IPV4_ETHER_TYPE, 8'd2, -1, 1);
        send_packet(64, IPV4_ETHER_TYPE, 8'd1, -1, 0);
        send_packet(80, IPV4_ETHER_TYPE, 8'd0, -1, 0);
        send_packet(64, 16'h86DD, 8'd64, -1, 0);
        send_packet(90, IPV4_ETHER_TYPE, 8'd30, 5, 0);

        // Random traffic, half back to back
        for (int p = 0; p < 60; p++) begin
            rnd  = $random(seed);
            kind = int'(rnd[2:0]);
            send_packet(64 + int'(rnd[15:8]) % 137,
                        (kind == 0) ? 16'h0806 : IPV4_ETHER_TYPE,
                        rnd[31:24],
                        (kind == 1) ? int'(rnd[19:16]) : -1,
                        rnd[20] ? 2 : 0);
        end
        @(posedge core_clk_ifc);
        in_valid <= 1'b0;
        in_last  <= 1'b0;

        wait_cycles = 0;
        while ((exp_data_q.size() != 0 || exp_status_q.size() != 0) && !timed_out) begin
            @(posedge core_clk_ifc);
            wait_cycles++;
            if (wait_cycles > 50) begin
                timed_out = 1'b1;
                $display("Timeout: %0d beats and %0d status pulses never came out",
                         exp_data_q.size(), exp_status_q.size());
            end
        end

        $display("Summary: %0d packets, %0d status pulses, %0d errors",
                 pkt_count, status_count, errors);
        if (errors == 0 && !timed_out && status_count == pkt_count) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
common/ipv4_fwd_pkg.sv
source/beat_counter.sv
source/pkt_parse_fsm.sv
source/hdr_checksum_verify.sv
source/ttl_rewrite.sv
source/ipv4_fwd_top.sv
verif/ipv4_fwd_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the IPv4 forwarding testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module ipv4_fwd_tb \
    -f list.f -o sim_ipv4_fwd
./obj_dir/sim_ipv4_fwd > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
